//--- rtl/fpu_op_pkg.sv
/*
  FPU lane operation definitions
  issued operation codes, execute unit classes and lane latency
*/
package fpu_op_pkg;

  // cycles from the issue edge to res_valid
  localparam int LANE_LATENCY = 3;

  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_rsub = 4'd2,
    op_cmp  = 4'd3,
    op_and  = 4'd4,
    op_or   = 4'd5,
    op_xor  = 4'd6,
    op_andn = 4'd7,
    op_copy = 4'd8
  } fpu_op_e;

  typedef enum logic [1:0] {
    unit_add   = 2'd0,
    unit_cmp   = 2'd1,
    unit_logic = 2'd2,
    unit_copy  = 2'd3
  } fpu_unit_e;

  typedef enum logic [1:0] {
    sel_and  = 2'd0,
    sel_or   = 2'd1,
    sel_xor  = 2'd2,
    sel_andn = 2'd3
  } logic_sel_e;

endpackage

//--- rtl/fpu_fmt_pkg.sv
/*
  FPU lane number format
  single-precision field layout, special values and exception flags
*/
package fpu_fmt_pkg;

  localparam int FP_WIDTH  = 32;
  localparam int EXP_WIDTH = 8;
  localparam int MAN_WIDTH = 23;
  localparam int EXC_WIDTH = 4;

  typedef logic [FP_WIDTH-1:0] fp_word_t;

  localparam logic [EXP_WIDTH-1:0] EXP_MAX = 8'd255;
  localparam fp_word_t QNAN = 32'h7fc00000;

  // bit positions in a compare result word
  localparam int CMP_LT = 0;
  localparam int CMP_EQ = 1;
  localparam int CMP_UN = 2;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic inexact;
  } exc_t;

endpackage

//--- rtl/fpu_stage_if.sv
/*
  FPU lane stage interfaces
  dec_if carries decoded controls and operands to execute,
  exe_if carries the execute result and flags to the result stage
*/
`timescale 1ns/1ps

interface dec_if;
  import fpu_op_pkg::*;
  import fpu_fmt_pkg::*;

  logic       valid;
  fpu_unit_e  unit;
  logic       negate_b;
  logic       swap;
  logic_sel_e lsel;
  fp_word_t   a;
  fp_word_t   b;

  modport src (output valid, unit, negate_b, swap, lsel, a, b);
  modport dst (input valid, unit, negate_b, swap, lsel, a, b);
endinterface

interface exe_if;
  import fpu_fmt_pkg::*;

  logic     valid;
  fp_word_t value;
  exc_t     exc;

  modport src (output valid, value, exc);
  modport dst (input valid, value, exc);
endinterface

//--- rtl/fpu_decode.sv
/*
  FPU lane decode stage
  registers the issued operation, picks forwarded operands
  and decodes the execute unit controls
*/
`timescale 1ns/1ps

module fpu_decode (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   op_valid,
  input  fpu_op_pkg::fpu_op_e    op,
  input  fpu_fmt_pkg::fp_word_t  a,
  input  fpu_fmt_pkg::fp_word_t  b,
  input  logic                   fwd_a,
  input  logic                   fwd_b,
  input  fpu_fmt_pkg::fp_word_t  last_res,
  dec_if.src                     dec
);
  import fpu_op_pkg::*;

  fpu_unit_e  unit_d;
  logic       negate_b_d;
  logic       swap_d;
  logic_sel_e lsel_d;

  always_comb begin
    unit_d     = unit_copy;
    negate_b_d = 1'b0;
    swap_d     = 1'b0;
    lsel_d     = sel_and;
    case (op)
      op_add:  unit_d = unit_add;
      op_sub: begin
        unit_d     = unit_add;
        negate_b_d = 1'b1;
      end
      // b - a, operands exchanged before the adder
      op_rsub: begin
        unit_d     = unit_add;
        negate_b_d = 1'b1;
        swap_d     = 1'b1;
      end
      op_cmp:  unit_d = unit_cmp;
      op_and: begin
        unit_d = unit_logic;
        lsel_d = sel_and;
      end
      op_or: begin
        unit_d = unit_logic;
        lsel_d = sel_or;
      end
      op_xor: begin
        unit_d = unit_logic;
        lsel_d = sel_xor;
      end
      op_andn: begin
        unit_d = unit_logic;
        lsel_d = sel_andn;
      end
      default: unit_d = unit_copy;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= op_valid;
    end
    dec.unit     <= unit_d;
    dec.negate_b <= negate_b_d;
    dec.swap     <= swap_d;
    dec.lsel     <= lsel_d;
    dec.a        <= fwd_a ? last_res : a;
    dec.b        <= fwd_b ? last_res : b;
  end

endmodule

//--- rtl/fpu_adder.sv
/*
  FPU single-precision adder
  combinational add/subtract, truncated toward zero,
  denormals flushed to zero, with exception detection
*/
`timescale 1ns/1ps

module fpu_adder (
  input  fpu_fmt_pkg::fp_word_t a,
  input  fpu_fmt_pkg::fp_word_t b,
  input  logic                  negate_b,
  output fpu_fmt_pkg::fp_word_t sum,
  output fpu_fmt_pkg::exc_t     exc
);
  import fpu_fmt_pkg::*;

  logic                 sa;
  logic                 sb;
  logic [EXP_WIDTH-1:0] ea;
  logic [EXP_WIDTH-1:0] eb;
  logic [MAN_WIDTH-1:0] ma;
  logic [MAN_WIDTH-1:0] mb;
  logic                 nan_in;
  logic                 inf_a;
  logic                 inf_b;
  logic                 eff_sub;
  logic                 a_big;
  logic                 s_big;
  logic [EXP_WIDTH-1:0] e_big;
  logic [EXP_WIDTH-1:0] e_small;
  logic [EXP_WIDTH-1:0] diff;
  logic [MAN_WIDTH:0]   sig_big;
  logic [MAN_WIDTH:0]   sig_small;
  logic [53:0]          shifted;
  logic [26:0]          small_al;
  logic [27:0]          mag;
  logic [4:0]           lz;
  logic [27:0]          norm;
  logic signed [9:0]    exp_n;

  // field split, denormals flushed, b sign flipped for subtract
  assign sa = a[FP_WIDTH-1];
  assign sb = b[FP_WIDTH-1] ^ negate_b;
  assign ea = a[FP_WIDTH-2 -: EXP_WIDTH];
  assign eb = b[FP_WIDTH-2 -: EXP_WIDTH];
  assign ma = (ea == '0) ? '0 : a[MAN_WIDTH-1:0];
  assign mb = (eb == '0) ? '0 : b[MAN_WIDTH-1:0];

  assign nan_in = (ea == EXP_MAX && ma != '0) || (eb == EXP_MAX && mb != '0);
  assign inf_a  = (ea == EXP_MAX) && (ma == '0);
  assign inf_b  = (eb == EXP_MAX) && (mb == '0);
  assign eff_sub = sa ^ sb;

  assign a_big     = {ea, ma} >= {eb, mb};
  assign s_big     = a_big ? sa : sb;
  assign e_big     = a_big ? ea : eb;
  assign e_small   = a_big ? eb : ea;
  assign sig_big   = a_big ? {ea != '0, ma} : {eb != '0, mb};
  assign sig_small = a_big ? {eb != '0, mb} : {ea != '0, ma};
  assign diff      = e_big - e_small;

  // two guard bits and a sticky bit below the significand
  always_comb begin
    shifted = {sig_small, 30'b0} >> diff;
    if (diff > 8'd26) begin
      small_al = {26'b0, |sig_small};
    end else begin
      small_al = {shifted[53:28], shifted[27] | (|shifted[26:0])};
    end
  end

  assign mag = eff_sub ? {1'b0, sig_big, 3'b0} - {1'b0, small_al}
                       : {1'b0, sig_big, 3'b0} + {1'b0, small_al};

  always_comb begin
    lz = 5'd0;
    for (int i = 0; i < 28; i++) begin
      if (mag[i]) lz = 5'(27 - i);
    end
  end

  assign norm  = mag << lz;
  assign exp_n = $signed({2'b0, e_big}) + 10'sd1 - $signed({5'b0, lz});

  always_comb begin
    exc = '0;
    if (nan_in || (inf_a && inf_b && eff_sub)) begin
      sum = QNAN;
      exc.invalid = 1'b1;
    end else if (inf_a) begin
      sum = {sa, EXP_MAX, {MAN_WIDTH{1'b0}}};
    end else if (inf_b) begin
      sum = {sb, EXP_MAX, {MAN_WIDTH{1'b0}}};
    end else if (mag == '0) begin
      // -0 only from -0 plus -0
      sum = {sa & sb, {(FP_WIDTH-1){1'b0}}};
    end else if (exp_n > 10'sd254) begin
      sum = {s_big, EXP_MAX - 8'd1, {MAN_WIDTH{1'b1}}};
      exc.overflow = 1'b1;
      exc.inexact  = 1'b1;
    end else if (exp_n < 10'sd1) begin
      sum = {s_big, {(FP_WIDTH-1){1'b0}}};
      exc.underflow = 1'b1;
      exc.inexact   = 1'b1;
    end else begin
      sum = {s_big, exp_n[EXP_WIDTH-1:0], norm[26:4]};
      exc.inexact = |norm[3:0];
    end
  end

endmodule

//--- rtl/fpu_execute.sv
/*
  FPU lane execute stage
  adder, compare and logic units, result select and register
*/
`timescale 1ns/1ps

module fpu_execute (
  input  logic clk,
  input  logic rst,
  dec_if.dst   dec,
  exe_if.src   exe
);
  import fpu_op_pkg::*;
  import fpu_fmt_pkg::*;

  fp_word_t              add_a;
  fp_word_t              add_b;
  fp_word_t              add_sum;
  exc_t                  add_exc;
  logic                  sa;
  logic                  sb;
  logic [FP_WIDTH-2:0]   mag_a;
  logic [FP_WIDTH-2:0]   mag_b;
  logic                  nan_a;
  logic                  nan_b;
  fp_word_t              cmp_val;
  fp_word_t              logic_val;
  fp_word_t              value_d;
  exc_t                  exc_d;

  assign add_a = dec.swap ? dec.b : dec.a;
  assign add_b = dec.swap ? dec.a : dec.b;

  fpu_adder u_adder (
    .a        (add_a),
    .b        (add_b),
    .negate_b (dec.negate_b),
    .sum      (add_sum),
    .exc      (add_exc)
  );

  // compare on flushed magnitudes
  assign sa    = dec.a[FP_WIDTH-1];
  assign sb    = dec.b[FP_WIDTH-1];
  assign mag_a = (dec.a[FP_WIDTH-2 -: EXP_WIDTH] == '0) ? '0 : dec.a[FP_WIDTH-2:0];
  assign mag_b = (dec.b[FP_WIDTH-2 -: EXP_WIDTH] == '0) ? '0 : dec.b[FP_WIDTH-2:0];
  assign nan_a = (dec.a[FP_WIDTH-2 -: EXP_WIDTH] == EXP_MAX) && (dec.a[MAN_WIDTH-1:0] != '0);
  assign nan_b = (dec.b[FP_WIDTH-2 -: EXP_WIDTH] == EXP_MAX) && (dec.b[MAN_WIDTH-1:0] != '0);

  always_comb begin
    cmp_val = '0;
    if (nan_a || nan_b) begin
      cmp_val[CMP_UN] = 1'b1;
    end else if (mag_a == mag_b && (sa == sb || mag_a == '0)) begin
      cmp_val[CMP_EQ] = 1'b1;
    end else if (sa != sb) begin
      cmp_val[CMP_LT] = sa;
    end else if (sa) begin
      cmp_val[CMP_LT] = mag_a > mag_b;
    end else begin
      cmp_val[CMP_LT] = mag_a < mag_b;
    end
  end

  always_comb begin
    case (dec.lsel)
      sel_and:  logic_val = dec.a & dec.b;
      sel_or:   logic_val = dec.a | dec.b;
      sel_xor:  logic_val = dec.a ^ dec.b;
      default:  logic_val = dec.a & ~dec.b;
    endcase
  end

  always_comb begin
    exc_d = '0;
    case (dec.unit)
      unit_add: begin
        value_d = add_sum;
        exc_d   = add_exc;
      end
      unit_cmp: begin
        value_d       = cmp_val;
        exc_d.invalid = cmp_val[CMP_UN];
      end
      unit_logic: value_d = logic_val;
      default:    value_d = dec.a;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      exe.valid <= 1'b0;
    end else begin
      exe.valid <= dec.valid;
    end
    exe.value <= value_d;
    exe.exc   <= exc_d;
  end

endmodule

//--- rtl/fpu_result.sv
/*
  FPU lane result stage
  holds the last lane result and raises the masked trap
*/
`timescale 1ns/1ps

module fpu_result (
  input  logic                              clk,
  input  logic                              rst,
  exe_if.dst                                exe,
  input  logic [fpu_fmt_pkg::EXC_WIDTH-1:0] exc_en,
  output logic                              res_valid,
  output fpu_fmt_pkg::fp_word_t             res,
  output fpu_fmt_pkg::exc_t                 exc,
  output logic                              exc_trap
);
  import fpu_fmt_pkg::*;

  logic [EXC_WIDTH-1:0] raised;

  // flags that are both set and enabled
  assign raised = exe.exc & exc_en;

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      res       <= '0;
      exc       <= '0;
      exc_trap  <= 1'b0;
    end else begin
      res_valid <= exe.valid;
      // res also feeds operand forwarding, so it only moves on valid
      if (exe.valid) begin
        res <= exe.value;
      end
      exc      <= exe.exc;
      exc_trap <= exe.valid & (|raised);
    end
  end

endmodule

//--- rtl/fpu_lane.sv
/*
  FPU execution lane, single precision
  decode, execute and result stages, three cycles issue to result
*/
`timescale 1ns/1ps

module fpu_lane (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  op_valid,
  input  fpu_op_pkg::fpu_op_e   op,
  input  fpu_fmt_pkg::fp_word_t a,
  input  fpu_fmt_pkg::fp_word_t b,
  input  logic                  fwd_a,
  input  logic                  fwd_b,
  input  logic [3:0]            exc_en,
  output logic                  res_valid,
  output fpu_fmt_pkg::fp_word_t res,
  output fpu_fmt_pkg::exc_t     exc,
  output logic                  exc_trap
);

  dec_if u_dec_bus ();
  exe_if u_exe_bus ();

  // res loops back for forwarding
  fpu_decode u_decode (
    .clk      (clk),
    .rst      (rst),
    .op_valid (op_valid),
    .op       (op),
    .a        (a),
    .b        (b),
    .fwd_a    (fwd_a),
    .fwd_b    (fwd_b),
    .last_res (res),
    .dec      (u_dec_bus)
  );

  fpu_execute u_execute (
    .clk (clk),
    .rst (rst),
    .dec (u_dec_bus),
    .exe (u_exe_bus)
  );

  fpu_result u_result (
    .clk       (clk),
    .rst       (rst),
    .exe       (u_exe_bus),
    .exc_en    (exc_en),
    .res_valid (res_valid),
    .res       (res),
    .exc       (exc),
    .exc_trap  (exc_trap)
  );

endmodule

//--- tb/fpu_lane_assert.sv
/*
  FPU lane assertions
  result timing, trap qualification and known result bits
*/
`timescale 1ns/1ps

module fpu_lane_assert (
  input logic                  clk,
  input logic                  rst,
  input logic                  op_valid,
  input logic                  res_valid,
  input fpu_fmt_pkg::fp_word_t res,
  input logic                  exc_trap
);
  import fpu_op_pkg::*;

  // fixed three stage latency, no stall
  a_latency: assert property (@(posedge clk) disable iff (rst)
    res_valid == $past(op_valid, LANE_LATENCY))
    else $error("res_valid does not follow op_valid by %0d cycles", LANE_LATENCY);

  a_trap: assert property (@(posedge clk) disable iff (rst) exc_trap |-> res_valid)
    else $error("exc_trap high without res_valid");

  a_known: assert property (@(posedge clk) disable iff (rst) res_valid |-> !$isunknown(res))
    else $error("res has unknown bits while res_valid is high");

endmodule

bind fpu_lane fpu_lane_assert u_lane_assert (.*);

//--- tb/fpu_lane_tb.sv
/*
  FPU lane testbench
  directed and LFSR-driven operations, reference model, in-order result check
*/
`timescale 1ns/1ps

module fpu_lane_tb;
  import fpu_op_pkg::*;
  import fpu_fmt_pkg::*;

  localparam int N_DIR = 22;
  localparam int N_RAND = 480;
  localparam int MAX_CYCLES = 2 * (N_DIR + N_RAND) + 100;
  localparam fp_word_t SIGN_BIT = 32'h80000000;

  // add sub add sub add add add sub rsub add sub, cmp x5, and or xor andn copy add
  localparam logic [3:0] DIR_OP [N_DIR] = '{
    4'd0, 4'd1, 4'd0, 4'd1, 4'd0, 4'd0, 4'd0, 4'd1, 4'd2, 4'd0, 4'd1,
    4'd3, 4'd3, 4'd3, 4'd3, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd0};
  localparam fp_word_t DIR_A [N_DIR] = '{
    32'h7f7fffff, 32'h00800001, 32'h7fc00000, 32'h7f800000, 32'hff800000,
    32'h00000001, 32'h80000000, 32'h3f800000, 32'h3f800000, 32'h3f800000,
    32'h3f800000, 32'h3f800000, 32'h80000000, 32'h7fc00001, 32'hc0000000,
    32'h00000005, 32'h12345678, 32'h12345678, 32'h12345678, 32'h12345678,
    32'h7fc00000, 32'h7f800000};
  localparam fp_word_t DIR_B [N_DIR] = '{
    32'h7f7fffff, 32'h00800000, 32'h3f800000, 32'h7f800000, 32'h3f800000,
    32'h3f800000, 32'h80000000, 32'h3f800000, 32'h40000000, 32'h33800000,
    32'h0d800000, 32'h40000000, 32'h00000000, 32'h3f800000, 32'hbf800000,
    32'h80000000, 32'h0f0f0f0f, 32'h0f0f0f0f, 32'h0f0f0f0f, 32'h0f0f0f0f,
    32'h00000000, 32'hff800000};

  typedef struct packed {
    fp_word_t res;
    exc_t     exc;
    logic     trap;
  } expect_t;

  logic       clk;
  logic       rst;
  logic       op_valid;
  fpu_op_e    op;
  fp_word_t   a;
  fp_word_t   b;
  logic       fwd_a;
  logic       fwd_b;
  logic [3:0] exc_en;
  logic       res_valid;
  fp_word_t   res;
  exc_t       exc;
  logic       exc_trap;

  expect_t    exp_q[$];
  fp_word_t   model_res = '0;
  logic [3:0] en_cur = '0;
  logic [31:0] lfsr = 32'hf9c9;
  int         errors = 0;
  int         cycles = 0;

  fpu_lane dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic fp_word_t special_word(input logic [2:0] idx);
    case (idx)
      3'd0: return 32'h00000000;
      3'd1: return 32'h80000000;
      3'd2: return 32'h7f800000;
      3'd3: return 32'hff800000;
      3'd4: return 32'h7fc00000;
      3'd5: return 32'h80012345;
      3'd6: return 32'h7f7fffff;
      default: return 32'h00800000;
    endcase
  endfunction

  function automatic fp_word_t rand_word();
    if (rand_bits(3) == 0) return special_word(3'(rand_bits(3)));
    return rand_bits(32);
  endfunction

  // half of the pairs get nearby exponents
  function automatic void rand_pair(output fp_word_t x, output fp_word_t y);
    x = rand_word();
    y = rand_word();
    if (rand_bits(1) == 1) y[30:23] = x[30:23] + 8'(rand_bits(3)) - 8'd4;
  endfunction

  function automatic logic is_nan(input fp_word_t x);
    return x[30:23] == 8'hff && x[22:0] != 23'd0;
  endfunction

  // exact sum on a wide grid, then cut toward zero
  function automatic fp_word_t ref_add(input fp_word_t x, input fp_word_t y, output exc_t fl);
    logic [7:0]   ex;
    logic [7:0]   ey;
    logic [7:0]   e_hi;
    logic [7:0]   e_lo;
    logic [23:0]  sig_x;
    logic [23:0]  sig_y;
    logic [23:0]  sig_hi;
    logic [23:0]  sig_lo;
    logic         sign_hi;
    logic [127:0] big;
    logic [127:0] lo_al;
    logic [127:0] mag;
    int           diff;
    int           p;
    int           e;
    fl = '0;
    ex = x[30:23];
    ey = y[30:23];
    sig_x = (ex == 8'd0) ? 24'd0 : {1'b1, x[22:0]};
    sig_y = (ey == 8'd0) ? 24'd0 : {1'b1, y[22:0]};
    if (is_nan(x) || is_nan(y) || (ex == 8'hff && ey == 8'hff && x[31] != y[31])) begin
      fl.invalid = 1'b1;
      return QNAN;
    end
    if (ex == 8'hff) return x;
    if (ey == 8'hff) return y;
    if ({ex, sig_x} >= {ey, sig_y}) begin
      e_hi = ex;
      e_lo = ey;
      sig_hi = sig_x;
      sig_lo = sig_y;
      sign_hi = x[31];
    end else begin
      e_hi = ey;
      e_lo = ex;
      sig_hi = sig_y;
      sig_lo = sig_x;
      sign_hi = y[31];
    end
    diff = int'(e_hi) - int'(e_lo);
    big = {104'd0, sig_hi} << 100;
    if (diff > 100) lo_al = {127'd0, sig_lo != 24'd0};
    else lo_al = ({104'd0, sig_lo} << 100) >> diff;
    mag = (x[31] != y[31]) ? big - lo_al : big + lo_al;
    if (mag == 128'd0) return {x[31] & y[31], 31'd0};
    p = 127;
    while (!mag[p]) p--;
    e = int'(e_hi) + p - 123;
    if (e > 254) begin
      fl.overflow = 1'b1;
      fl.inexact = 1'b1;
      return {sign_hi, 8'hfe, 23'h7fffff};
    end
    if (e < 1) begin
      fl.underflow = 1'b1;
      fl.inexact = 1'b1;
      return {sign_hi, 31'd0};
    end
    fl.inexact = (mag & ((128'd1 << (p - 23)) - 128'd1)) != 128'd0;
    return {sign_hi, e[7:0], 23'(mag >> (p - 23))};
  endfunction

  // signed ordering key, both zeros map to 0
  function automatic logic signed [32:0] order_key(input fp_word_t x);
    logic [32:0] m;
    m = (x[30:23] == 8'd0) ? 33'd0 : {2'b00, x[30:0]};
    return x[31] ? -$signed(m) : $signed(m);
  endfunction

  function automatic fp_word_t ref_cmp(input fp_word_t x, input fp_word_t y, output exc_t fl);
    fp_word_t r;
    fl = '0;
    r = '0;
    if (is_nan(x) || is_nan(y)) begin
      r[CMP_UN] = 1'b1;
      fl.invalid = 1'b1;
    end else begin
      r[CMP_LT] = order_key(x) < order_key(y);
      r[CMP_EQ] = order_key(x) == order_key(y);
    end
    return r;
  endfunction

  function automatic expect_t ref_model(input fpu_op_e o, input fp_word_t x,
                                        input fp_word_t y, input logic [3:0] en);
    expect_t ex;
    exc_t    fl;
    fl = '0;
    case (o)
      op_add:  ex.res = ref_add(x, y, fl);
      op_sub:  ex.res = ref_add(x, y ^ SIGN_BIT, fl);
      op_rsub: ex.res = ref_add(y, x ^ SIGN_BIT, fl);
      op_cmp:  ex.res = ref_cmp(x, y, fl);
      op_and:  ex.res = x & y;
      op_or:   ex.res = x | y;
      op_xor:  ex.res = x ^ y;
      op_andn: ex.res = x & ~y;
      default: ex.res = x;
    endcase
    ex.exc = fl;
    ex.trap = |(fl & en);
    return ex;
  endfunction

  task automatic issue(input fpu_op_e o, input fp_word_t x, input fp_word_t y,
                       input logic fa, input logic fb);
    exp_q.push_back(ref_model(o, fa ? model_res : x, fb ? model_res : y, en_cur));
    op_valid <= 1'b1;
    op <= o;
    a <= x;
    b <= y;
    fwd_a <= fa;
    fwd_b <= fb;
    @(posedge clk);
  endtask

  task automatic idle();
    op_valid <= 1'b0;
    fwd_a <= 1'b0;
    fwd_b <= 1'b0;
    @(posedge clk);
  endtask

  // wait for in-flight results, at most one lane latency
  task automatic drain();
    int n;
    idle();
    for (n = 0; n < LANE_LATENCY + 1 && exp_q.size() != 0; n++) @(posedge clk);
  endtask

  initial begin : stimulus
    fpu_op_e    o;
    fp_word_t   x;
    fp_word_t   y;
    logic [1:0] f;
    int         i;
    rst = 1'b1;
    op_valid = 1'b0;
    op = op_add;
    a = '0;
    b = '0;
    fwd_a = 1'b0;
    fwd_b = 1'b0;
    exc_en = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    en_cur = 4'(rand_bits(4));
    exc_en <= en_cur;
    for (i = 0; i < N_DIR; i++) begin
      issue(fpu_op_e'(DIR_OP[i]), DIR_A[i], DIR_B[i], 1'b0, 1'b0);
    end
    for (i = 0; i < N_RAND; i++) begin
      o = fpu_op_e'(4'(rand_bits(4) % 9));
      rand_pair(x, y);
      if (i % 8 == 7) begin
        // lane empty, so new enables and forwarding are safe here
        drain();
        en_cur = 4'(rand_bits(4));
        exc_en <= en_cur;
        f = 2'(rand_bits(2));
        if (f == 2'b00) f = 2'b01;
        issue(o, x, y, f[0], f[1]);
      end else if (rand_bits(2) == 0) begin
        idle();
      end else begin
        issue(o, x, y, 1'b0, 1'b0);
      end
    end
    drain();
    if (exp_q.size() != 0) begin
      $display("%0d issued operations never produced a result", exp_q.size());
      errors++;
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  always @(negedge clk) begin : compare
    expect_t ex;
    if (!rst && res_valid) begin
      if (exp_q.size() == 0) begin
        $display("res_valid at %0t with no operation in flight", $time);
        errors++;
      end else begin
        ex = exp_q.pop_front();
        if (res !== ex.res) begin
          $display("ERROR %0t res: got %h expected %h", $time, res, ex.res);
          errors++;
        end
        if (exc !== ex.exc) begin
          $display("ERROR %0t exc: got %b expected %b", $time, exc, ex.exc);
          errors++;
        end
        if (exc_trap !== ex.trap) begin
          $display("ERROR %0t exc_trap: got %b expected %b", $time, exc_trap, ex.trap);
          errors++;
        end
        model_res = ex.res;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("errors: %0d", errors);
      $display("TB FAILED");
      $finish;
    end
  end

endmodule

//--- list.f
rtl/fpu_op_pkg.sv
rtl/fpu_fmt_pkg.sv
rtl/fpu_stage_if.sv
rtl/fpu_decode.sv
rtl/fpu_adder.sv
rtl/fpu_execute.sv
rtl/fpu_result.sv
rtl/fpu_lane.sv
tb/fpu_lane_assert.sv
tb/fpu_lane_tb.sv

//--- Makefile
SIM     = verilator
FLAGS   = --binary --timing --assert --timescale 1ns/1ps
TOP     = fpu_lane_tb
FLIST   = list.f
OBJ_DIR = obj_dir
LOG     = sim.log
PASS    = TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
